// File: build.f
+incdir+verification
rtl/pcie_cfg_pkg.sv
rtl/axil_ctrl_port.sv
rtl/host_dma_channel.sv
rtl/board_gpio.sv
rtl/pcie_config.sv
verification/tb_pcie_config.sv

// File: rtl/axil_ctrl_port.sv
`timescale 1ns/100ps

module axil_ctrl_port
  import pcie_cfg_pkg::*;
(
  input  logic                        pcie_clk,
  input  logic                        pcie_rst,

  input  logic [LOCAL_ADDR_WIDTH-1:0] s_axil_awaddr_i,
  input  logic                        s_axil_awvalid_i,
  output logic                        s_axil_awready_o,
  input  logic [DATA_WIDTH-1:0]       s_axil_wdata_i,
  input  logic [STRB_WIDTH-1:0]       s_axil_wstrb_i,
  input  logic                        s_axil_wvalid_i,
  output logic                        s_axil_wready_o,
  output logic [1:0]                  s_axil_bresp_o,
  output logic                        s_axil_bvalid_o,
  input  logic                        s_axil_bready_i,
  input  logic [LOCAL_ADDR_WIDTH-1:0] s_axil_araddr_i,
  input  logic                        s_axil_arvalid_i,
  output logic                        s_axil_arready_o,
  output logic [DATA_WIDTH-1:0]       s_axil_rdata_o,
  output logic [1:0]                  s_axil_rresp_o,
  output logic                        s_axil_rvalid_o,
  input  logic                        s_axil_rready_i,

  input  logic [DATA_WIDTH-1:0]       gpio_rd_data_i,
  input  logic                        gpio_rd_hit_i,
  input  logic [DATA_WIDTH-1:0]       rd_chan_rd_data_i,
  input  logic                        rd_chan_rd_hit_i,
  input  logic [DATA_WIDTH-1:0]       wr_chan_rd_data_i,
  input  logic                        wr_chan_rd_hit_i,
  input  logic                        dma_enable_rd_i,

  output logic                        wr_en_o,
  output logic [LOCAL_ADDR_WIDTH-1:0] wr_addr_o,
  output logic [DATA_WIDTH-1:0]       wr_data_o,
  output logic [STRB_WIDTH-1:0]       wr_strb_o,
  output logic                        rd_en_o,
  output logic [LOCAL_ADDR_WIDTH-1:0] rd_addr_o
);

  logic [DATA_WIDTH-1:0] rd_data_sel;

  assign s_axil_bresp_o = 2'b00; // Always OKAY
  assign s_axil_rresp_o = 2'b00;

  // One outstanding response per direction
  assign wr_en_o = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
  assign rd_en_o = s_axil_arvalid_i && !s_axil_rvalid_o;

  assign wr_addr_o = {s_axil_awaddr_i[LOCAL_ADDR_WIDTH-1:2], 2'b00};
  assign rd_addr_o = {s_axil_araddr_i[LOCAL_ADDR_WIDTH-1:2], 2'b00};
  assign wr_data_o = s_axil_wdata_i;
  assign wr_strb_o = s_axil_wstrb_i;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      s_axil_awready_o <= 1'b0;
      s_axil_wready_o  <= 1'b0;
      s_axil_bvalid_o  <= 1'b0;
    end else begin
      s_axil_awready_o <= wr_en_o; // Single cycle pulse
      s_axil_wready_o  <= wr_en_o;
      if (wr_en_o) begin
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      s_axil_arready_o <= 1'b0;
      s_axil_rvalid_o  <= 1'b0;
    end else begin
      s_axil_arready_o <= rd_en_o;
      if (rd_en_o) begin
        s_axil_rvalid_o <= 1'b1;
      end else if (s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

  // Local registers first, then whichever block claims the offset
  always_comb begin
    rd_data_sel = '0;
    case (rd_addr_o)
      REG_FW_ID:      rd_data_sel = FW_ID;
      REG_FW_VER:     rd_data_sel = FW_VER;
      REG_BOARD_ID:   rd_data_sel = BOARD_ID;
      REG_BOARD_VER:  rd_data_sel = BOARD_VER;
      REG_DMA_ENABLE: rd_data_sel = DATA_WIDTH'(dma_enable_rd_i);
      default: begin
        if (gpio_rd_hit_i) begin
          rd_data_sel = gpio_rd_data_i;
        end else if (rd_chan_rd_hit_i) begin
          rd_data_sel = rd_chan_rd_data_i;
        end else if (wr_chan_rd_hit_i) begin
          rd_data_sel = wr_chan_rd_data_i;
        end
      end
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (rd_en_o) begin
      s_axil_rdata_o <= rd_data_sel;
    end
  end

endmodule

// File: rtl/board_gpio.sv
`timescale 1ns/100ps

module board_gpio
  import pcie_cfg_pkg::*;
(
  input  logic                        pcie_clk,
  input  logic                        pcie_rst,
  input  logic                        wr_en_i,
  input  logic [LOCAL_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [DATA_WIDTH-1:0]       wr_data_i,
  input  logic [STRB_WIDTH-1:0]       wr_strb_i,
  input  logic [LOCAL_ADDR_WIDTH-1:0] rd_addr_i,

  input  logic                        sfp_scl_i,
  output logic                        sfp_scl_o,
  output logic                        sfp_scl_t_o,
  input  logic                        sfp1_sda_i,
  output logic                        sfp1_sda_o,
  output logic                        sfp1_sda_t_o,
  input  logic                        sfp2_sda_i,
  output logic                        sfp2_sda_o,
  output logic                        sfp2_sda_t_o,
  input  logic                        eeprom_scl_i,
  output logic                        eeprom_scl_o,
  output logic                        eeprom_scl_t_o,
  input  logic                        eeprom_sda_i,
  output logic                        eeprom_sda_o,
  output logic                        eeprom_sda_t_o,

  output logic [DATA_WIDTH-1:0]       rd_data_o,
  output logic                        rd_hit_o
);

  // Open drain, line released while high
  assign sfp_scl_t_o    = sfp_scl_o;
  assign sfp1_sda_t_o   = sfp1_sda_o;
  assign sfp2_sda_t_o   = sfp2_sda_o;
  assign eeprom_scl_t_o = eeprom_scl_o;
  assign eeprom_sda_t_o = eeprom_sda_o;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      sfp_scl_o    <= 1'b1;
      sfp1_sda_o   <= 1'b1;
      sfp2_sda_o   <= 1'b1;
      eeprom_scl_o <= 1'b1;
      eeprom_sda_o <= 1'b1;
    end else if (wr_en_i && (wr_addr_i == REG_GPIO_OUT)) begin
      if (wr_strb_i[SFP_SCL_BIT/8]) begin // SFP byte
        sfp_scl_o  <= wr_data_i[SFP_SCL_BIT];
        sfp1_sda_o <= wr_data_i[SFP1_SDA_BIT];
        sfp2_sda_o <= wr_data_i[SFP2_SDA_BIT];
      end
      if (wr_strb_i[EEPROM_SCL_BIT/8]) begin // EEPROM byte
        eeprom_scl_o <= wr_data_i[EEPROM_SCL_BIT];
        eeprom_sda_o <= wr_data_i[EEPROM_SDA_BIT];
      end
    end
  end

  always_comb begin
    rd_data_o = '0;
    rd_hit_o  = 1'b1;
    case (rd_addr_i)
      REG_GPIO_OUT: begin
        rd_data_o[SFP_SCL_BIT]    = sfp_scl_o;
        rd_data_o[SFP1_SDA_BIT]   = sfp1_sda_o;
        rd_data_o[SFP2_SDA_BIT]   = sfp2_sda_o;
        rd_data_o[EEPROM_SCL_BIT] = eeprom_scl_o;
        rd_data_o[EEPROM_SDA_BIT] = eeprom_sda_o;
      end
      REG_GPIO_IN: begin
        // Pin levels as sampled
        rd_data_o[SFP_SCL_BIT]    = sfp_scl_i;
        rd_data_o[SFP1_SDA_BIT]   = sfp1_sda_i;
        rd_data_o[SFP2_SDA_BIT]   = sfp2_sda_i;
        rd_data_o[EEPROM_SCL_BIT] = eeprom_scl_i;
        rd_data_o[EEPROM_SDA_BIT] = eeprom_sda_i;
      end
      default: rd_hit_o = 1'b0;
    endcase
  end

endmodule

// File: rtl/host_dma_channel.sv
`timescale 1ns/100ps

module host_dma_channel
  import pcie_cfg_pkg::*;
#(
  parameter logic [LOCAL_ADDR_WIDTH-1:0] BASE_ADDR = DMA_RD_BASE,
  parameter int PCIE_ADDR_WIDTH = 64,
  parameter int RAM_ADDR_WIDTH  = 32,
  parameter int DMA_LEN_WIDTH   = 16,
  parameter int TAG_WIDTH       = 32
) (
  input  logic                        pcie_clk,
  input  logic                        pcie_rst,
  input  logic                        wr_en_i,
  input  logic [LOCAL_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [DATA_WIDTH-1:0]       wr_data_i,
  input  logic                        rd_en_i,
  input  logic [LOCAL_ADDR_WIDTH-1:0] rd_addr_i,

  output logic [PCIE_ADDR_WIDTH-1:0]  desc_pcie_addr_o,
  output logic [RAM_ADDR_WIDTH-1:0]   desc_ram_addr_o,
  output logic [DMA_LEN_WIDTH-1:0]    desc_len_o,
  output logic [TAG_WIDTH-1:0]        desc_tag_o,
  output logic                        desc_valid_o,
  input  logic                        desc_ready_i,
  input  logic [TAG_WIDTH-1:0]        status_tag_i,
  input  logic                        status_valid_i,

  output logic [DATA_WIDTH-1:0]       rd_data_o,
  output logic                        rd_hit_o
);

  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_LO_OFS  = BASE_ADDR + DESC_ADDR_LO;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] ADDR_HI_OFS  = BASE_ADDR + DESC_ADDR_HI;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] RAM_ADDR_OFS = BASE_ADDR + DESC_RAM_ADDR;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] LEN_OFS      = BASE_ADDR + DESC_LEN;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] TAG_OFS      = BASE_ADDR + DESC_TAG;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] STATUS_OFS   = BASE_ADDR + DESC_STATUS;

  logic                    tag_wr;
  logic                    status_rd;
  logic [TAG_WIDTH-1:0]    status_tags;
  logic [2*DATA_WIDTH-1:0] pcie_addr_ext;

  assign tag_wr    = wr_en_i && (wr_addr_i == TAG_OFS);
  assign status_rd = rd_en_i && (rd_addr_i == STATUS_OFS);

  always_ff @(posedge pcie_clk) begin
    if (wr_en_i) begin
      case (wr_addr_i)
        ADDR_LO_OFS:  desc_pcie_addr_o[DATA_WIDTH-1:0] <= wr_data_i;
        ADDR_HI_OFS:  desc_pcie_addr_o[PCIE_ADDR_WIDTH-1:DATA_WIDTH] <=
                        wr_data_i[PCIE_ADDR_WIDTH-DATA_WIDTH-1:0];
        RAM_ADDR_OFS: desc_ram_addr_o <= wr_data_i[RAM_ADDR_WIDTH-1:0];
        LEN_OFS:      desc_len_o      <= wr_data_i[DMA_LEN_WIDTH-1:0];
        TAG_OFS:      desc_tag_o      <= wr_data_i[TAG_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // A tag write while valid is high simply reissues
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
    end else if (tag_wr) begin
      desc_valid_o <= 1'b1;
    end else if (desc_ready_i) begin
      desc_valid_o <= 1'b0;
    end
  end

  // Completion tags accumulate until the host reads them
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      status_tags <= '0;
    end else if (status_rd) begin
      status_tags <= status_valid_i ? status_tag_i : '0;
    end else if (status_valid_i) begin
      status_tags <= status_tags | status_tag_i;
    end
  end

  assign pcie_addr_ext = (2*DATA_WIDTH)'(desc_pcie_addr_o);

  always_comb begin
    rd_data_o = '0;
    rd_hit_o  = 1'b1;
    case (rd_addr_i)
      ADDR_LO_OFS:  rd_data_o = pcie_addr_ext[DATA_WIDTH-1:0];
      ADDR_HI_OFS:  rd_data_o = pcie_addr_ext[2*DATA_WIDTH-1:DATA_WIDTH];
      RAM_ADDR_OFS: rd_data_o = DATA_WIDTH'(desc_ram_addr_o);
      LEN_OFS:      rd_data_o = DATA_WIDTH'(desc_len_o);
      TAG_OFS:      rd_data_o = DATA_WIDTH'(desc_tag_o);
      STATUS_OFS:   rd_data_o = DATA_WIDTH'(status_tags);
      default:      rd_hit_o  = 1'b0;
    endcase
  end

endmodule

// File: rtl/pcie_cfg_pkg.sv
package pcie_cfg_pkg;

  // Bus widths
  localparam int LOCAL_ADDR_WIDTH = 16;
  localparam int DATA_WIDTH       = 32;
  localparam int STRB_WIDTH       = DATA_WIDTH / 8;

  // Firmware and board identification
  localparam logic [DATA_WIDTH-1:0] FW_ID     = 32'h0000_0000;
  localparam logic [DATA_WIDTH-1:0] FW_VER    = 32'h0000_0001;
  localparam logic [DATA_WIDTH-1:0] BOARD_ID  = 32'h1ce4_0003;
  localparam logic [DATA_WIDTH-1:0] BOARD_VER = 32'h0000_0001;

  // ID registers
  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_FW_ID     = 16'h0000;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_FW_VER    = 16'h0004;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_BOARD_ID  = 16'h0008;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_BOARD_VER = 16'h000C;

  // GPIO registers
  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_GPIO_OUT = 16'h0100;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_GPIO_IN  = 16'h0104;

  localparam logic [LOCAL_ADDR_WIDTH-1:0] REG_DMA_ENABLE = 16'h0400;

  // Host DMA channel windows
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DMA_RD_BASE = 16'h0440;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DMA_WR_BASE = 16'h0460;

  // Offsets within a channel window
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DESC_ADDR_LO  = 16'h0000;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DESC_ADDR_HI  = 16'h0004;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DESC_RAM_ADDR = 16'h0008;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DESC_LEN      = 16'h0010;
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DESC_TAG      = 16'h0014; // Starts the descriptor
  localparam logic [LOCAL_ADDR_WIDTH-1:0] DESC_STATUS   = 16'h0018; // Clear on read

  // I2C lines in the GPIO registers
  localparam int SFP_SCL_BIT    = 16;
  localparam int SFP1_SDA_BIT   = 17;
  localparam int SFP2_SDA_BIT   = 18;
  localparam int EEPROM_SCL_BIT = 24;
  localparam int EEPROM_SDA_BIT = 25;

endpackage

// File: rtl/pcie_config.sv
`timescale 1ns/100ps

module pcie_config
  import pcie_cfg_pkg::*;
#(
  parameter int PCIE_ADDR_WIDTH = 64,
  parameter int RAM_ADDR_WIDTH  = 32,
  parameter int DMA_LEN_WIDTH   = 16,
  parameter int TAG_WIDTH       = 32
) (
  input  logic                        pcie_clk,
  input  logic                        pcie_rst,

  input  logic [LOCAL_ADDR_WIDTH-1:0] s_axil_awaddr_i,
  input  logic                        s_axil_awvalid_i,
  output logic                        s_axil_awready_o,
  input  logic [DATA_WIDTH-1:0]       s_axil_wdata_i,
  input  logic [STRB_WIDTH-1:0]       s_axil_wstrb_i,
  input  logic                        s_axil_wvalid_i,
  output logic                        s_axil_wready_o,
  output logic [1:0]                  s_axil_bresp_o,
  output logic                        s_axil_bvalid_o,
  input  logic                        s_axil_bready_i,
  input  logic [LOCAL_ADDR_WIDTH-1:0] s_axil_araddr_i,
  input  logic                        s_axil_arvalid_i,
  output logic                        s_axil_arready_o,
  output logic [DATA_WIDTH-1:0]       s_axil_rdata_o,
  output logic [1:0]                  s_axil_rresp_o,
  output logic                        s_axil_rvalid_o,
  input  logic                        s_axil_rready_i,

  // Host read channel
  output logic [PCIE_ADDR_WIDTH-1:0]  host_dma_rd_desc_pcie_addr_o,
  output logic [RAM_ADDR_WIDTH-1:0]   host_dma_rd_desc_ram_addr_o,
  output logic [DMA_LEN_WIDTH-1:0]    host_dma_rd_desc_len_o,
  output logic [TAG_WIDTH-1:0]        host_dma_rd_desc_tag_o,
  output logic                        host_dma_rd_desc_valid_o,
  input  logic                        host_dma_rd_desc_ready_i,
  input  logic [TAG_WIDTH-1:0]        host_dma_rd_status_tag_i,
  input  logic                        host_dma_rd_status_valid_i,

  // Host write channel
  output logic [PCIE_ADDR_WIDTH-1:0]  host_dma_wr_desc_pcie_addr_o,
  output logic [RAM_ADDR_WIDTH-1:0]   host_dma_wr_desc_ram_addr_o,
  output logic [DMA_LEN_WIDTH-1:0]    host_dma_wr_desc_len_o,
  output logic [TAG_WIDTH-1:0]        host_dma_wr_desc_tag_o,
  output logic                        host_dma_wr_desc_valid_o,
  input  logic                        host_dma_wr_desc_ready_i,
  input  logic [TAG_WIDTH-1:0]        host_dma_wr_status_tag_i,
  input  logic                        host_dma_wr_status_valid_i,

  input  logic                        sfp_scl_i,
  output logic                        sfp_scl_o,
  output logic                        sfp_scl_t_o,
  input  logic                        sfp1_sda_i,
  output logic                        sfp1_sda_o,
  output logic                        sfp1_sda_t_o,
  input  logic                        sfp2_sda_i,
  output logic                        sfp2_sda_o,
  output logic                        sfp2_sda_t_o,
  input  logic                        eeprom_scl_i,
  output logic                        eeprom_scl_o,
  output logic                        eeprom_scl_t_o,
  input  logic                        eeprom_sda_i,
  output logic                        eeprom_sda_o,
  output logic                        eeprom_sda_t_o,

  output logic                        pcie_dma_enable_o,
  output logic                        msi_irq_o
);

  logic                        wr_en;
  logic [LOCAL_ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0]       wr_data;
  logic [STRB_WIDTH-1:0]       wr_strb;
  logic                        rd_en;
  logic [LOCAL_ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0]       gpio_rd_data;
  logic                        gpio_rd_hit;
  logic [DATA_WIDTH-1:0]       rd_chan_rd_data;
  logic                        rd_chan_rd_hit;
  logic [DATA_WIDTH-1:0]       wr_chan_rd_data;
  logic                        wr_chan_rd_hit;

  axil_ctrl_port axil_port (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .s_axil_awaddr_i   (s_axil_awaddr_i),
    .s_axil_awvalid_i  (s_axil_awvalid_i),
    .s_axil_awready_o  (s_axil_awready_o),
    .s_axil_wdata_i    (s_axil_wdata_i),
    .s_axil_wstrb_i    (s_axil_wstrb_i),
    .s_axil_wvalid_i   (s_axil_wvalid_i),
    .s_axil_wready_o   (s_axil_wready_o),
    .s_axil_bresp_o    (s_axil_bresp_o),
    .s_axil_bvalid_o   (s_axil_bvalid_o),
    .s_axil_bready_i   (s_axil_bready_i),
    .s_axil_araddr_i   (s_axil_araddr_i),
    .s_axil_arvalid_i  (s_axil_arvalid_i),
    .s_axil_arready_o  (s_axil_arready_o),
    .s_axil_rdata_o    (s_axil_rdata_o),
    .s_axil_rresp_o    (s_axil_rresp_o),
    .s_axil_rvalid_o   (s_axil_rvalid_o),
    .s_axil_rready_i   (s_axil_rready_i),
    .gpio_rd_data_i    (gpio_rd_data),
    .gpio_rd_hit_i     (gpio_rd_hit),
    .rd_chan_rd_data_i (rd_chan_rd_data),
    .rd_chan_rd_hit_i  (rd_chan_rd_hit),
    .wr_chan_rd_data_i (wr_chan_rd_data),
    .wr_chan_rd_hit_i  (wr_chan_rd_hit),
    .dma_enable_rd_i   (pcie_dma_enable_o),
    .wr_en_o           (wr_en),
    .wr_addr_o         (wr_addr),
    .wr_data_o         (wr_data),
    .wr_strb_o         (wr_strb),
    .rd_en_o           (rd_en),
    .rd_addr_o         (rd_addr)
  );

  host_dma_channel #(
    .BASE_ADDR       (DMA_RD_BASE),
    .PCIE_ADDR_WIDTH (PCIE_ADDR_WIDTH),
    .RAM_ADDR_WIDTH  (RAM_ADDR_WIDTH),
    .DMA_LEN_WIDTH   (DMA_LEN_WIDTH),
    .TAG_WIDTH       (TAG_WIDTH)
  ) rd_chan (
    .pcie_clk         (pcie_clk),
    .pcie_rst         (pcie_rst),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .rd_en_i          (rd_en),
    .rd_addr_i        (rd_addr),
    .desc_pcie_addr_o (host_dma_rd_desc_pcie_addr_o),
    .desc_ram_addr_o  (host_dma_rd_desc_ram_addr_o),
    .desc_len_o       (host_dma_rd_desc_len_o),
    .desc_tag_o       (host_dma_rd_desc_tag_o),
    .desc_valid_o     (host_dma_rd_desc_valid_o),
    .desc_ready_i     (host_dma_rd_desc_ready_i),
    .status_tag_i     (host_dma_rd_status_tag_i),
    .status_valid_i   (host_dma_rd_status_valid_i),
    .rd_data_o        (rd_chan_rd_data),
    .rd_hit_o         (rd_chan_rd_hit)
  );

  host_dma_channel #(
    .BASE_ADDR       (DMA_WR_BASE),
    .PCIE_ADDR_WIDTH (PCIE_ADDR_WIDTH),
    .RAM_ADDR_WIDTH  (RAM_ADDR_WIDTH),
    .DMA_LEN_WIDTH   (DMA_LEN_WIDTH),
    .TAG_WIDTH       (TAG_WIDTH)
  ) wr_chan (
    .pcie_clk         (pcie_clk),
    .pcie_rst         (pcie_rst),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .rd_en_i          (rd_en),
    .rd_addr_i        (rd_addr),
    .desc_pcie_addr_o (host_dma_wr_desc_pcie_addr_o),
    .desc_ram_addr_o  (host_dma_wr_desc_ram_addr_o),
    .desc_len_o       (host_dma_wr_desc_len_o),
    .desc_tag_o       (host_dma_wr_desc_tag_o),
    .desc_valid_o     (host_dma_wr_desc_valid_o),
    .desc_ready_i     (host_dma_wr_desc_ready_i),
    .status_tag_i     (host_dma_wr_status_tag_i),
    .status_valid_i   (host_dma_wr_status_valid_i),
    .rd_data_o        (wr_chan_rd_data),
    .rd_hit_o         (wr_chan_rd_hit)
  );

  board_gpio gpio (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .wr_en_i        (wr_en),
    .wr_addr_i      (wr_addr),
    .wr_data_i      (wr_data),
    .wr_strb_i      (wr_strb),
    .rd_addr_i      (rd_addr),
    .sfp_scl_i      (sfp_scl_i),
    .sfp_scl_o      (sfp_scl_o),
    .sfp_scl_t_o    (sfp_scl_t_o),
    .sfp1_sda_i     (sfp1_sda_i),
    .sfp1_sda_o     (sfp1_sda_o),
    .sfp1_sda_t_o   (sfp1_sda_t_o),
    .sfp2_sda_i     (sfp2_sda_i),
    .sfp2_sda_o     (sfp2_sda_o),
    .sfp2_sda_t_o   (sfp2_sda_t_o),
    .eeprom_scl_i   (eeprom_scl_i),
    .eeprom_scl_o   (eeprom_scl_o),
    .eeprom_scl_t_o (eeprom_scl_t_o),
    .eeprom_sda_i   (eeprom_sda_i),
    .eeprom_sda_o   (eeprom_sda_o),
    .eeprom_sda_t_o (eeprom_sda_t_o),
    .rd_data_o      (gpio_rd_data),
    .rd_hit_o       (gpio_rd_hit)
  );

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      pcie_dma_enable_o <= 1'b0;
    end else if (wr_en && (wr_addr == REG_DMA_ENABLE)) begin
      pcie_dma_enable_o <= wr_data[0];
    end
  end

  // Any completion interrupts the host
  assign msi_irq_o = host_dma_rd_status_valid_i || host_dma_wr_status_valid_i;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  -f build.f --top-module tb_pcie_config -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: verification/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

logic [31:0] lcg_state = 32'h8ce6_900d;

// Two LCG steps, upper halves only
function automatic logic [31:0] next_rand();
  logic [31:0] hi;
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  hi = lcg_state;
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return {hi[31:16], lcg_state[31:16]};
endfunction

function automatic int rand_below(input int n);
  return int'(next_rand() % 32'(n));
endfunction

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("ERR %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic report_fault(input string msg);
  errors++;
  $display("%s", msg);
endtask

task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
  int delay;
  delay = rand_below(4);
  @(negedge pcie_clk);
  s_axil_awaddr_i  = addr;
  s_axil_wdata_i   = data;
  s_axil_wstrb_i   = strb;
  s_axil_awvalid_i = 1'b1;
  s_axil_wvalid_i  = 1'b1;
  @(negedge pcie_clk);
  while (!s_axil_awready_o) @(negedge pcie_clk);
  s_axil_awvalid_i = 1'b0;
  s_axil_wvalid_i  = 1'b0;
  if (!s_axil_wready_o) report_fault("wready did not pulse together with awready");
  check_val("bresp", 32'd0, 32'(s_axil_bresp_o)); // OKAY
  repeat (delay) begin
    if (!s_axil_bvalid_o) report_fault("bvalid dropped before bready was given");
    @(negedge pcie_clk);
  end
  if (!s_axil_bvalid_o) report_fault("bvalid low when bready was given");
  s_axil_bready_i = 1'b1;
  @(negedge pcie_clk);
  s_axil_bready_i = 1'b0;
  if (s_axil_bvalid_o) report_fault("bvalid still high after the bready handshake");
endtask

task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
  int delay;
  delay = rand_below(4);
  @(negedge pcie_clk);
  s_axil_araddr_i  = addr;
  s_axil_arvalid_i = 1'b1;
  @(negedge pcie_clk);
  while (!s_axil_arready_o) @(negedge pcie_clk);
  s_axil_arvalid_i = 1'b0;
  data = s_axil_rdata_o;
  check_val("rresp", 32'd0, 32'(s_axil_rresp_o));
  repeat (delay) begin
    if (!s_axil_rvalid_o || s_axil_rdata_o !== data)
      report_fault("read response changed before rready was given");
    @(negedge pcie_clk);
  end
  if (!s_axil_rvalid_o) report_fault("rvalid low when rready was given");
  s_axil_rready_i = 1'b1;
  @(negedge pcie_clk);
  s_axil_rready_i = 1'b0;
  if (s_axil_rvalid_o) report_fault("rvalid still high after the rready handshake");
endtask

`endif

// File: verification/tb_pcie_config.sv
`timescale 1ns/100ps

module tb_pcie_config
  import pcie_cfg_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TRANS  = 150;

  int checks = 0;
  int errors = 0;

  logic        pcie_clk;
  logic        pcie_rst;
  logic [15:0] s_axil_awaddr_i;
  logic        s_axil_awvalid_i;
  logic        s_axil_awready_o;
  logic [31:0] s_axil_wdata_i;
  logic [3:0]  s_axil_wstrb_i;
  logic        s_axil_wvalid_i;
  logic        s_axil_wready_o;
  logic [1:0]  s_axil_bresp_o;
  logic        s_axil_bvalid_o;
  logic        s_axil_bready_i;
  logic [15:0] s_axil_araddr_i;
  logic        s_axil_arvalid_i;
  logic        s_axil_arready_o;
  logic [31:0] s_axil_rdata_o;
  logic [1:0]  s_axil_rresp_o;
  logic        s_axil_rvalid_o;
  logic        s_axil_rready_i;
  logic [63:0] rd_pa, wr_pa;
  logic [31:0] rd_ra, wr_ra, rd_tag, wr_tag, rd_st_tag, wr_st_tag;
  logic [15:0] rd_len, wr_len;
  logic        rd_valid, wr_valid, rd_ready, wr_ready, rd_st_valid, wr_st_valid;
  logic [4:0]  pins_i, pins_o, pins_t; // scl, sda1, sda2, eeprom scl, eeprom sda
  logic        dma_enable, msi_irq;

  logic [31:0] gpio_model;
  logic [31:0] rd_status_model, wr_status_model;
  logic [31:0] rdata;

  pcie_config #(
    .PCIE_ADDR_WIDTH (64),
    .RAM_ADDR_WIDTH  (32),
    .DMA_LEN_WIDTH   (16),
    .TAG_WIDTH       (32)
  ) dut0 (
    .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
    .s_axil_awaddr_i(s_axil_awaddr_i), .s_axil_awvalid_i(s_axil_awvalid_i),
    .s_axil_awready_o(s_axil_awready_o), .s_axil_wdata_i(s_axil_wdata_i),
    .s_axil_wstrb_i(s_axil_wstrb_i), .s_axil_wvalid_i(s_axil_wvalid_i),
    .s_axil_wready_o(s_axil_wready_o), .s_axil_bresp_o(s_axil_bresp_o),
    .s_axil_bvalid_o(s_axil_bvalid_o), .s_axil_bready_i(s_axil_bready_i),
    .s_axil_araddr_i(s_axil_araddr_i), .s_axil_arvalid_i(s_axil_arvalid_i),
    .s_axil_arready_o(s_axil_arready_o), .s_axil_rdata_o(s_axil_rdata_o),
    .s_axil_rresp_o(s_axil_rresp_o), .s_axil_rvalid_o(s_axil_rvalid_o),
    .s_axil_rready_i(s_axil_rready_i),
    .host_dma_rd_desc_pcie_addr_o(rd_pa), .host_dma_rd_desc_ram_addr_o(rd_ra),
    .host_dma_rd_desc_len_o(rd_len), .host_dma_rd_desc_tag_o(rd_tag),
    .host_dma_rd_desc_valid_o(rd_valid), .host_dma_rd_desc_ready_i(rd_ready),
    .host_dma_rd_status_tag_i(rd_st_tag), .host_dma_rd_status_valid_i(rd_st_valid),
    .host_dma_wr_desc_pcie_addr_o(wr_pa), .host_dma_wr_desc_ram_addr_o(wr_ra),
    .host_dma_wr_desc_len_o(wr_len), .host_dma_wr_desc_tag_o(wr_tag),
    .host_dma_wr_desc_valid_o(wr_valid), .host_dma_wr_desc_ready_i(wr_ready),
    .host_dma_wr_status_tag_i(wr_st_tag), .host_dma_wr_status_valid_i(wr_st_valid),
    .sfp_scl_i(pins_i[0]), .sfp_scl_o(pins_o[0]), .sfp_scl_t_o(pins_t[0]),
    .sfp1_sda_i(pins_i[1]), .sfp1_sda_o(pins_o[1]), .sfp1_sda_t_o(pins_t[1]),
    .sfp2_sda_i(pins_i[2]), .sfp2_sda_o(pins_o[2]), .sfp2_sda_t_o(pins_t[2]),
    .eeprom_scl_i(pins_i[3]), .eeprom_scl_o(pins_o[3]), .eeprom_scl_t_o(pins_t[3]),
    .eeprom_sda_i(pins_i[4]), .eeprom_sda_o(pins_o[4]), .eeprom_sda_t_o(pins_t[4]),
    .pcie_dma_enable_o(dma_enable), .msi_irq_o(msi_irq)
  );

  `include "tb_axil_tasks.svh"

  always #(CLK_PERIOD/2) pcie_clk = ~pcie_clk;

  // Register image of the five I2C lines
  function automatic logic [31:0] pins_word(input logic [4:0] p);
    logic [31:0] w;
    w = '0;
    w[SFP_SCL_BIT]    = p[0];
    w[SFP1_SDA_BIT]   = p[1];
    w[SFP2_SDA_BIT]   = p[2];
    w[EEPROM_SCL_BIT] = p[3];
    w[EEPROM_SDA_BIT] = p[4];
    return w;
  endfunction

  task automatic run_gpio_test();
    logic [31:0] data, sfp_mask, ee_mask;
    logic [3:0]  strb;
    sfp_mask = pins_word(5'b00111);
    ee_mask  = pins_word(5'b11000);
    repeat (12) begin
      data = next_rand();
      strb = 4'(next_rand());
      axil_write(REG_GPIO_OUT, data, strb);
      if (strb[2]) gpio_model = (gpio_model & ~sfp_mask) | (data & sfp_mask);
      if (strb[3]) gpio_model = (gpio_model & ~ee_mask) | (data & ee_mask);
      check_val("gpio outputs", gpio_model, pins_word(pins_o));
      check_val("gpio tristate", gpio_model, pins_word(pins_t));
      axil_read(REG_GPIO_OUT, rdata);
      check_val("gpio out read", gpio_model, rdata);
    end
    repeat (4) begin
      @(negedge pcie_clk);
      pins_i = 5'(next_rand());
      axil_read(REG_GPIO_IN, rdata);
      check_val("gpio in read", pins_word(pins_i), rdata);
    end
  endtask

  task automatic run_desc_test(input bit wr_side);
    logic [63:0] pa;
    logic [31:0] ra, tag, tmp;
    logic [15:0] len, base;
    int          delay;
    base = wr_side ? DMA_WR_BASE : DMA_RD_BASE;
    pa   = {next_rand(), next_rand()};
    ra   = next_rand();
    tmp  = next_rand();
    len  = tmp[15:0];
    tag  = next_rand();
    axil_write(base + DESC_ADDR_LO, pa[31:0], 4'hf);
    axil_write(base + DESC_ADDR_HI, pa[63:32], 4'hf);
    axil_write(base + DESC_RAM_ADDR, ra, 4'hf);
    axil_write(base + DESC_LEN, {16'd0, len}, 4'hf);
    axil_write(base + DESC_TAG, tag, 4'hf);
    delay = rand_below(6);
    repeat (delay + 1) begin
      check_val("desc valid", 32'd1, 32'(wr_side ? wr_valid : rd_valid));
      check_val("other valid", 32'd0, 32'(wr_side ? rd_valid : wr_valid));
      check_val("desc addr lo", pa[31:0], wr_side ? wr_pa[31:0] : rd_pa[31:0]);
      check_val("desc addr hi", pa[63:32], wr_side ? wr_pa[63:32] : rd_pa[63:32]);
      check_val("desc ram addr", ra, wr_side ? wr_ra : rd_ra);
      check_val("desc len", {16'd0, len}, {16'd0, wr_side ? wr_len : rd_len});
      check_val("desc tag", tag, wr_side ? wr_tag : rd_tag);
      @(negedge pcie_clk);
    end
    if (wr_side) wr_ready = 1'b1;
    else rd_ready = 1'b1;
    @(negedge pcie_clk);
    wr_ready = 1'b0;
    rd_ready = 1'b0;
    check_val("desc valid after ready", 32'd0, 32'(wr_side ? wr_valid : rd_valid));
    axil_read(base + DESC_TAG, rdata);
    check_val("desc tag read", tag, rdata);
  endtask

  task automatic pulse_completion();
    logic [31:0] r, tag;
    r   = next_rand();
    tag = r[0] ? (32'd1 << r[5:1]) : next_rand(); // Single or multi-bit
    @(negedge pcie_clk);
    if (r[8]) begin
      wr_st_tag       = tag;
      wr_st_valid     = 1'b1;
      wr_status_model = wr_status_model | tag;
    end else begin
      rd_st_tag       = tag;
      rd_st_valid     = 1'b1;
      rd_status_model = rd_status_model | tag;
    end
    #(CLK_PERIOD/4);
    check_val("msi during completion", 32'd1, 32'(msi_irq));
    @(negedge pcie_clk);
    rd_st_valid = 1'b0;
    wr_st_valid = 1'b0;
    #(CLK_PERIOD/4);
    check_val("msi idle", 32'd0, 32'(msi_irq));
  endtask

  task automatic run_status_test();
    repeat (2) begin
      repeat (6) pulse_completion();
      axil_read(DMA_RD_BASE + DESC_STATUS, rdata);
      check_val("rd status", rd_status_model, rdata);
      axil_read(DMA_WR_BASE + DESC_STATUS, rdata);
      check_val("wr status", wr_status_model, rdata);
      rd_status_model = '0;
      wr_status_model = '0;
      axil_read(DMA_RD_BASE + DESC_STATUS, rdata);
      check_val("rd status cleared", 32'd0, rdata);
      axil_read(DMA_WR_BASE + DESC_STATUS, rdata);
      check_val("wr status cleared", 32'd0, rdata);
    end
  endtask

  task automatic run_enable_test();
    logic [31:0] data;
    repeat (8) begin
      data = next_rand();
      axil_write(REG_DMA_ENABLE, data, 4'hf);
      check_val("dma enable out", {31'd0, data[0]}, 32'(dma_enable));
      axil_read(REG_DMA_ENABLE, rdata);
      check_val("dma enable read", {31'd0, data[0]}, rdata);
    end
  endtask

  initial begin
    pcie_clk = 1'b0;
    pcie_rst = 1'b1;
    s_axil_awaddr_i = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i = '0;
    s_axil_wstrb_i = '0;
    s_axil_wvalid_i = 1'b0;
    s_axil_bready_i = 1'b0;
    s_axil_araddr_i = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i = 1'b0;
    rd_ready = 1'b0;
    wr_ready = 1'b0;
    rd_st_tag = '0;
    wr_st_tag = '0;
    rd_st_valid = 1'b0;
    wr_st_valid = 1'b0;
    pins_i = 5'b11111;
    gpio_model = pins_word(5'b11111); // Lines released after reset
    rd_status_model = '0;
    wr_status_model = '0;
    repeat (10) @(negedge pcie_clk);
    pcie_rst = 1'b0;

    check_val("reset gpio outputs", gpio_model, pins_word(pins_o));
    check_val("reset desc valids", 32'd0, {30'd0, wr_valid, rd_valid});
    check_val("reset dma enable", 32'd0, 32'(dma_enable));
    axil_read(REG_FW_ID, rdata);
    check_val("fw id", FW_ID, rdata);
    axil_read(REG_FW_VER, rdata);
    check_val("fw ver", FW_VER, rdata);
    axil_read(REG_BOARD_ID, rdata);
    check_val("board id", BOARD_ID, rdata);
    axil_read(REG_BOARD_VER, rdata);
    check_val("board ver", BOARD_VER, rdata);
    axil_read(16'h0200, rdata);
    check_val("unmapped read", 32'd0, rdata);

    run_gpio_test();
    repeat (3) run_desc_test(1'b0);
    repeat (3) run_desc_test(1'b1);
    run_status_test();
    run_enable_test();

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Generous bound of 40 cycles per transaction
  initial begin
    #(NUM_TRANS * 40 * CLK_PERIOD);
    $display("Watchdog expired before the tests finished, errors %0d", errors);
    $display("Errors found");
    $finish;
  end

endmodule
